//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FLIST     ?= sources.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD VFLAGS"

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

//--- bench/exu_checks.svh
`ifndef EXU_CHECKS_SVH
`define EXU_CHECKS_SVH

// youngest writer of rs in the model window, or the register-file value.
function automatic void pick_source(input logic [3:0] rs, input word_t regv,
                                    output word_t val, output logic pend);
    logic found;
    found = 1'b0;
    val   = regv;
    pend  = 1'b0;
    for (int i = 0; i < `EXU_FWD_DEPTH; i++) begin
        if (!found && rs != 4'd0 && m_rd[i] == rs) begin
            found = 1'b1;
            val   = m_data[i];
            pend  = m_pend[i];
        end
    end
endfunction

function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
    case (op)
        alu_add:    return a + b;
        alu_sub:    return a - b;
        alu_and:    return a & b;
        alu_or:     return a | b;
        alu_xor:    return a ^ b;
        alu_sll:    return a << b[4:0];
        alu_srl:    return a >> b[4:0];
        alu_sra:    return word_t'($signed(a) >>> b[4:0]);
        alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
        default:    return b;    // lui.
    endcase
endfunction

function automatic logic branch_ref(input br_op_e op, input word_t a, input word_t b);
    case (op)
        br_eq:   return a == b;
        br_ne:   return a != b;
        br_lt:   return $signed(a) < $signed(b);
        br_ge:   return $signed(a) >= $signed(b);
        br_ltu:  return a < b;
        br_geu:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// outputs hold while the memory stage stalls.
hold_check: assert property (@(posedge clk) disable iff (rst)
    !out_ready |=> $stable(out_valid) && $stable(out_result) && $stable(out_pc)
        && $stable(out_rd) && $stable(out_csr_wdata) && $stable(out_store_data)
        && $stable(out_gpr_we) && $stable(out_is_load) && $stable(out_mem_size)
        && $stable(out_csr_we) && $stable(redirect_pc))
    else begin
        assert_errors++;
        $display("outputs changed while out_ready was low");
    end

ready_check: assert property (@(posedge clk) disable iff (rst) !out_ready |-> !in_ready)
    else begin
        assert_errors++;
        $display("in_ready was high while out_ready was low");
    end

valid_check: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready && !redirect_valid) |=> out_valid)
    else begin
        assert_errors++;
        $display("accepted instruction gave no out_valid one cycle later");
    end

`endif

//--- bench/exu_tb.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_tb;

    import exu_pkg::*;

    localparam int plan_insts  = 60;
    localparam int cycle_limit = plan_insts * 20 + 200;

    typedef struct {
        word_t      pc;
        logic [3:0] rd;
        logic       gpr_we;
        word_t      result;
        word_t      store;
        logic       is_load;
        mem_size_e  mem_size;
        logic       csr_we;
        word_t      csr_wdata;
    } bundle_t;

    logic clk;
    logic rst;
    logic in_valid, in_ready;
    logic [3:0] rs1, rs2, rd;
    word_t pc, imm, reg1, reg2, csr_data, load_data;
    alu_op_e alu_op;
    br_op_e br_op;
    logic src1_is_pc, src2_is_imm, is_branch, is_jump, is_jalr, is_trap_ret, is_load;
    mem_size_e mem_size;
    logic gpr_we;
    csr_op_e csr_op;
    logic out_ready, pc_update, load_done;
    logic out_valid, out_gpr_we, out_is_load, out_csr_we, redirect_valid;
    word_t out_pc, out_result, out_store_data, out_csr_wdata, redirect_pc;
    logic [3:0] out_rd;
    mem_size_e out_mem_size;

    // model state.
    logic [3:0] m_rd   [`EXU_FWD_DEPTH];
    word_t      m_data [`EXU_FWD_DEPTH];
    logic       m_pend [`EXU_FWD_DEPTH];
    logic       m_redirect;
    word_t      m_target;
    bundle_t    expect_q[$];
    logic       check_due;
    logic       last_ready;
    int         accept_count;
    int         val_errors;
    int         assert_errors;
    int         cycles;

    `include "exu_checks.svh"

    exu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            val_errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // reference side, sampled before the edge updates any flop.
    always @(posedge clk) begin
        word_t s1, s2, a, b, res, nxt, wb;
        logic p1, p2, req, drop;
        bundle_t e;
        if (!rst) begin
            drop = m_redirect;    // push and drop see the redirect state from before the edge.
            pick_source(rs1, reg1, s1, p1);
            pick_source(rs2, reg2, s2, p2);
            last_ready = out_ready;
            if (in_valid) begin
                compare_word("in_ready", {31'd0, in_ready},
                             {31'd0, out_ready && !p1 && !p2});
            end
            if (in_valid && in_ready) begin
                accept_count++;
                a   = src1_is_pc ? pc : s1;
                b   = src2_is_imm ? imm : s2;
                res = alu_ref(alu_op, a, b);
                nxt = is_trap_ret ? csr_data : (is_jalr ? (res & ~32'd1) : pc + imm);
                req = ((is_branch && branch_ref(br_op, s1, s2)) || is_jump || is_jalr
                       || is_trap_ret) && (nxt != pc + 32'd4);
                if (csr_op != csr_none || is_trap_ret) wb = csr_data;
                else if (is_jump || is_jalr) wb = pc + 32'd4;
                else wb = res;
                if (!drop) begin
                    e.pc        = pc;
                    e.rd        = rd;
                    e.gpr_we    = gpr_we;
                    e.result    = wb;
                    e.store     = s2;
                    e.is_load   = is_load;
                    e.mem_size  = mem_size;
                    e.csr_we    = csr_op != csr_none;
                    e.csr_wdata = (csr_op == csr_rw) ? s1 :
                                  (csr_op == csr_rs) ? (s1 | csr_data) : 32'd0;
                    expect_q.push_back(e);
                    check_due = 1'b1;
                end
            end
            if (in_valid && in_ready && !drop && req) begin
                m_redirect = 1'b1;
                m_target   = nxt;
            end else if (pc_update) begin
                m_redirect = 1'b0;
            end
            // fill first, so a load that moves on this edge keeps its data.
            if (load_done) begin
                for (int i = `EXU_FWD_DEPTH - 1; i >= 0; i--) begin
                    if (m_pend[i] && load_done) begin
                        m_pend[i] = 1'b0;
                        m_data[i] = load_data;
                        break;
                    end
                end
            end
            if (in_valid && in_ready && !drop && gpr_we && rd != 4'd0) begin
                for (int i = `EXU_FWD_DEPTH - 1; i > 0; i--) begin
                    m_rd[i]   = m_rd[i-1];
                    m_data[i] = m_data[i-1];
                    m_pend[i] = m_pend[i-1];
                end
                m_rd[0]   = rd;
                m_data[0] = wb;
                m_pend[0] = is_load;
            end
        end
    end

    always @(negedge clk) begin
        bundle_t e;
        if (!rst) begin
            if (check_due) begin
                check_due = 1'b0;
                compare_word("out_valid", {31'd0, out_valid}, 32'd1);
                if (expect_q.size() > 0) begin
                    e = expect_q.pop_front();
                    compare_word("out_pc", out_pc, e.pc);
                    compare_word("out_rd", {28'd0, out_rd}, {28'd0, e.rd});
                    compare_word("out_gpr_we", {31'd0, out_gpr_we}, {31'd0, e.gpr_we});
                    compare_word("out_result", out_result, e.result);
                    compare_word("out_store_data", out_store_data, e.store);
                    compare_word("out_is_load", {31'd0, out_is_load}, {31'd0, e.is_load});
                    compare_word("out_mem_size", {30'd0, out_mem_size}, {30'd0, e.mem_size});
                    compare_word("out_csr_we", {31'd0, out_csr_we}, {31'd0, e.csr_we});
                    compare_word("out_csr_wdata", out_csr_wdata, e.csr_wdata);
                end
            end else if (last_ready) begin
                compare_word("out_valid", {31'd0, out_valid}, 32'd0);
            end
            compare_word("redirect_valid", {31'd0, redirect_valid}, {31'd0, m_redirect});
            if (m_redirect) compare_word("redirect_pc", redirect_pc, m_target);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic clear_fields();
        {rs1, rs2, rd} = '0;
        {pc, imm, reg1, reg2, csr_data} = '0;
        alu_op = alu_add;
        br_op  = br_eq;
        {src1_is_pc, src2_is_imm, is_branch, is_jump, is_jalr, is_trap_ret, is_load} = '0;
        mem_size = mem_word;
        gpr_we   = 1'b0;
        csr_op   = csr_none;
    endtask

    task automatic wait_accept(input int n);
        while (accept_count == n) @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send();
        int n;
        n = accept_count;
        in_valid = 1'b1;
        @(negedge clk);
        wait_accept(n);
    endtask

    task automatic fill_pulse(input word_t v);
        load_done = 1'b1;
        load_data = v;
        @(negedge clk);
        load_done = 1'b0;
    endtask

    task automatic fetch_moved();
        pc_update = 1'b1;
        @(negedge clk);
        pc_update = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] r, input word_t v, input logic load);
        clear_fields();
        rd          = r;
        imm         = v;
        src2_is_imm = 1'b1;
        alu_op      = alu_pass_b;
        gpr_we      = 1'b1;
        is_load     = load;
        pc          = $urandom & ~32'd3;
        send();
    endtask

    task automatic read_regs(input logic [3:0] a, input logic [3:0] b);
        clear_fields();
        rs1    = a;
        rs2    = b;
        reg1   = $urandom;
        reg2   = $urandom;
        alu_op = alu_xor;
        pc     = $urandom & ~32'd3;
    endtask

    initial begin
        int n;
        void'($urandom(32'hb7225116));
        {accept_count, val_errors, assert_errors, cycles} = '0;
        for (int i = 0; i < `EXU_FWD_DEPTH; i++) begin
            m_rd[i]   = '0;
            m_data[i] = '0;
            m_pend[i] = 1'b0;
        end
        m_redirect = 1'b0;
        m_target   = '0;
        check_due  = 1'b0;
        last_ready = 1'b0;
        clear_fields();
        in_valid  = 1'b0;
        out_ready = 1'b1;
        pc_update = 1'b0;
        load_done = 1'b0;
        load_data = '0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // random alu work with no writers.
        for (int i = 0; i < 30; i++) begin
            clear_fields();
            rs1 = $urandom_range(1, 15);
            rs2 = $urandom_range(1, 15);
            reg1 = $urandom;
            reg2 = $urandom;
            imm  = $urandom;
            alu_op = alu_op_e'($urandom_range(0, 10));
            src2_is_imm = $urandom_range(0, 1);
            mem_size = mem_size_e'($urandom_range(0, 2));
            send();
        end

        // forwarding chain.
        write_reg(4'd1, $urandom, 1'b0);
        write_reg(4'd1, $urandom, 1'b0);
        write_reg(4'd0, $urandom, 1'b0);    // x0 stays out of the window.
        read_regs(4'd1, 4'd0);
        send();
        read_regs(4'd1, 4'd1);
        send();
        for (int r = 2; r < 6; r++) write_reg(r[3:0], $urandom, 1'b0);
        read_regs(4'd1, 4'd5);
        send();    // x1 now older than four writers.

        // load hazards.
        write_reg(4'd6, 32'h0, 1'b1);
        read_regs(4'd6, 4'd0);
        n = accept_count;
        in_valid = 1'b1;
        repeat (3) @(negedge clk);
        fill_pulse($urandom);
        wait_accept(n);
        write_reg(4'd7, 32'h0, 1'b1);
        write_reg(4'd8, 32'h0, 1'b1);
        read_regs(4'd8, 4'd0);
        n = accept_count;
        in_valid = 1'b1;
        repeat (2) @(negedge clk);
        fill_pulse(32'h7777_0007);    // older load only.
        repeat (2) @(negedge clk);
        fill_pulse(32'h8888_0008);
        wait_accept(n);
        read_regs(4'd7, 4'd8);
        send();

        // branches and jumps.
        read_regs(4'd11, 4'd12);
        reg2 = reg1;
        is_branch = 1'b1;
        imm = 32'h40;
        send();
        read_regs(4'd11, 4'd12);
        send();
        read_regs(4'd11, 4'd12);
        send();
        fetch_moved();
        read_regs(4'd0, 4'd0);
        is_jump = 1'b1;
        rd = 4'd13;
        gpr_we = 1'b1;
        imm = 32'h100;
        src1_is_pc = 1'b1;
        src2_is_imm = 1'b1;
        alu_op = alu_add;
        send();
        fetch_moved();
        read_regs(4'd11, 4'd0);
        is_jalr = 1'b1;
        rd = 4'd13;
        gpr_we = 1'b1;
        imm = 32'h21;
        src2_is_imm = 1'b1;
        alu_op = alu_add;
        send();
        fetch_moved();
        read_regs(4'd11, 4'd12);
        reg2 = reg1;
        is_branch = 1'b1;
        br_op = br_ne;
        imm = 32'h80;
        send();

        // csr write data and trap return.
        read_regs(4'd11, 4'd0);
        csr_op = csr_rw;
        csr_data = $urandom;
        rd = 4'd14;
        gpr_we = 1'b1;
        send();
        read_regs(4'd11, 4'd0);
        csr_op = csr_rs;
        csr_data = $urandom;
        send();
        read_regs(4'd0, 4'd0);
        is_trap_ret = 1'b1;
        csr_data = 32'h0000_0800;
        send();
        fetch_moved();

        // memory stage stall.
        read_regs(4'd12, 4'd11);
        send();
        read_regs(4'd11, 4'd12);
        out_ready = 1'b0;
        n = accept_count;
        in_valid = 1'b1;
        repeat (5) @(negedge clk);
        out_ready = 1'b1;
        wait_accept(n);
        repeat (4) @(negedge clk);

        if (expect_q.size() != 0) begin
            val_errors++;
            $display("%0d expected results never appeared", expect_q.size());
        end
        $display("value errors %0d, assertion errors %0d", val_errors, assert_errors);
        if (val_errors == 0 && assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- logic/exec_core.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exec_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [`EXU_REG_W-1:0]  rs1,
    input  logic [`EXU_REG_W-1:0]  rs2,
    input  logic [`EXU_REG_W-1:0]  rd,
    input  logic [`EXU_XLEN-1:0]   pc,
    input  logic [`EXU_XLEN-1:0]   imm,
    input  logic                   src1_is_pc,
    input  logic                   src2_is_imm,
    input  logic                   is_branch,
    input  logic                   is_jump,
    input  logic                   is_jalr,
    input  logic                   is_trap_ret,
    input  logic                   is_load,
    input  exu_pkg::mem_size_e     mem_size,
    input  logic                   gpr_we,
    input  exu_pkg::csr_op_e       csr_op,
    input  logic [`EXU_XLEN-1:0]   csr_data,
    input  logic [`EXU_XLEN-1:0]   src1,
    input  logic [`EXU_XLEN-1:0]   src2,
    input  logic                   stall,
    input  logic [`EXU_XLEN-1:0]   alu_result,
    input  logic                   alu_taken,
    input  logic                   out_ready,
    input  logic                   pc_update,
    output logic                   in_ready,
    output logic [`EXU_XLEN-1:0]   alu_a,
    output logic [`EXU_XLEN-1:0]   alu_b,
    output logic                   push,
    output logic [`EXU_REG_W-1:0]  push_rd,
    output logic [`EXU_XLEN-1:0]   push_data,
    output logic                   push_pending,
    output logic                   out_valid,
    output logic [`EXU_XLEN-1:0]   out_pc,
    output logic [`EXU_REG_W-1:0]  out_rd,
    output logic                   out_gpr_we,
    output logic [`EXU_XLEN-1:0]   out_result,
    output logic [`EXU_XLEN-1:0]   out_store_data,
    output logic                   out_is_load,
    output exu_pkg::mem_size_e     out_mem_size,
    output logic                   out_csr_we,
    output logic [`EXU_XLEN-1:0]   out_csr_wdata,
    output logic                   redirect_valid,
    output logic [`EXU_XLEN-1:0]   redirect_pc
);

    import exu_pkg::*;

    logic  accept;
    logic  drop;
    logic  is_link;
    logic  has_target;
    logic  redirect_req;
    word_t pc_plus4;
    word_t next_pc;
    word_t wb_value;
    word_t csr_wdata;

    assign in_ready   = out_ready && !stall;
    assign accept     = in_valid && in_ready;
    assign drop       = redirect_valid;    // wrong path until the fetch side moves.

    assign alu_a = src1_is_pc ? pc : src1;
    assign alu_b = src2_is_imm ? imm : src2;

    assign is_link  = is_jump || is_jalr;
    assign pc_plus4 = pc + 'd4;

    always_comb begin
        if (is_trap_ret) begin
            next_pc = csr_data;    // mtvec or mepc from the csr file.
        end else if (is_jalr) begin
            next_pc = {alu_result[`EXU_XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc + imm;
        end
    end

    assign has_target   = (is_branch && alu_taken) || is_link || is_trap_ret;
    assign redirect_req = has_target && (next_pc != pc_plus4);

    always_comb begin
        if ((csr_op != csr_none) || is_trap_ret) begin
            wb_value = csr_data;
        end else if (is_link) begin
            wb_value = pc_plus4;
        end else begin
            wb_value = alu_result;
        end
    end

    always_comb begin
        case (csr_op)
            csr_rw:  csr_wdata = src1;
            csr_rs:  csr_wdata = src1 | csr_data;
            default: csr_wdata = '0;
        endcase
    end

    // a load enters the window pending and waits for its fill.
    assign push         = accept && !drop && gpr_we && (rd != '0);
    assign push_rd      = rd;
    assign push_data    = wb_value;
    assign push_pending = is_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (accept && !drop && redirect_req) begin
            redirect_valid <= 1'b1;
        end else if (pc_update) begin
            redirect_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !drop && redirect_req) begin
            redirect_pc <= next_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_gpr_we  <= 1'b0;
            out_is_load <= 1'b0;
            out_csr_we  <= 1'b0;
        end else if (out_ready) begin
            out_valid <= accept && !drop;
            if (accept) begin
                out_gpr_we  <= gpr_we;
                out_is_load <= is_load;
                out_csr_we  <= csr_op != csr_none;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc         <= pc;
            out_rd         <= rd;
            out_result     <= wb_value;
            out_store_data <= src2;
            out_mem_size   <= mem_size;
            out_csr_wdata  <= csr_wdata;
        end
    end

endmodule

//--- logic/exu_alu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_alu (
    input  exu_pkg::alu_op_e     op,
    input  exu_pkg::br_op_e      br_op,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    input  logic [`EXU_XLEN-1:0] cmp_a,
    input  logic [`EXU_XLEN-1:0] cmp_b,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 taken
);

    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       cmp_eq;
    logic       cmp_lt_s;
    logic       cmp_lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    // branch compare works on the raw register values.
    assign cmp_eq   = cmp_a == cmp_b;
    assign cmp_lt_s = $signed(cmp_a) < $signed(cmp_b);
    assign cmp_lt_u = cmp_a < cmp_b;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            alu_slt: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            end
            alu_sltu: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            end
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    always_comb begin
        case (br_op)
            br_eq:   taken = cmp_eq;
            br_ne:   taken = !cmp_eq;
            br_lt:   taken = cmp_lt_s;
            br_ge:   taken = !cmp_lt_s;
            br_ltu:  taken = cmp_lt_u;
            br_geu:  taken = !cmp_lt_u;
            default: taken = 1'b0;    // unused codes never branch.
        endcase
    end

endmodule

//--- logic/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// width of every data word in the stage.
`define EXU_XLEN 32

// sixteen architectural registers.
`define EXU_REG_W 4

// number of entries in the forwarding window.
// any value from 2 to 8 works.
`define EXU_FWD_DEPTH 4

`endif

//--- logic/exu_pkg.sv
`include "exu_macros.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]  word_t;
    typedef logic [`EXU_REG_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10    // lui.
    } alu_op_e;

    typedef enum logic [2:0] {
        br_eq  = 3'd0,
        br_ne  = 3'd1,
        br_lt  = 3'd2,
        br_ge  = 3'd3,
        br_ltu = 3'd4,
        br_geu = 3'd5
    } br_op_e;

    typedef enum logic [1:0] {
        csr_none = 2'd0,
        csr_rw   = 2'd1,
        csr_rs   = 2'd2
    } csr_op_e;

    // access size, only carried through to the memory stage.
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

endpackage

//--- logic/exu_top.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`EXU_REG_W-1:0] rs1,
    input  logic [`EXU_REG_W-1:0] rs2,
    input  logic [`EXU_REG_W-1:0] rd,
    input  logic [`EXU_XLEN-1:0]  pc,
    input  logic [`EXU_XLEN-1:0]  imm,
    input  logic [`EXU_XLEN-1:0]  reg1,
    input  logic [`EXU_XLEN-1:0]  reg2,
    input  exu_pkg::alu_op_e      alu_op,
    input  exu_pkg::br_op_e       br_op,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  is_branch,
    input  logic                  is_jump,
    input  logic                  is_jalr,
    input  logic                  is_trap_ret,
    input  logic                  is_load,
    input  exu_pkg::mem_size_e    mem_size,
    input  logic                  gpr_we,
    input  exu_pkg::csr_op_e      csr_op,
    input  logic [`EXU_XLEN-1:0]  csr_data,
    input  logic                  out_ready,
    input  logic                  pc_update,
    input  logic                  load_done,
    input  logic [`EXU_XLEN-1:0]  load_data,
    output logic                  out_valid,
    output logic [`EXU_XLEN-1:0]  out_pc,
    output logic [`EXU_REG_W-1:0] out_rd,
    output logic                  out_gpr_we,
    output logic [`EXU_XLEN-1:0]  out_result,
    output logic [`EXU_XLEN-1:0]  out_store_data,
    output logic                  out_is_load,
    output exu_pkg::mem_size_e    out_mem_size,
    output logic                  out_csr_we,
    output logic [`EXU_XLEN-1:0]  out_csr_wdata,
    output logic                  redirect_valid,
    output logic [`EXU_XLEN-1:0]  redirect_pc
);

    import exu_pkg::*;

    word_t    src1;
    word_t    src2;
    logic     stall;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_taken;
    logic     push;
    reg_idx_t push_rd;
    word_t    push_data;
    logic     push_pending;

    reg_idx_t slot_rd      [`EXU_FWD_DEPTH];
    word_t    slot_data    [`EXU_FWD_DEPTH];
    logic     slot_pending [`EXU_FWD_DEPTH];

    // bit i+1 feeds slot i. the token leaving slot 0 found no pending load.
    logic [`EXU_FWD_DEPTH:0] fill_chain;

    assign fill_chain[`EXU_FWD_DEPTH] = load_done;

    exec_core u_core (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .pc             (pc),
        .imm            (imm),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .is_branch      (is_branch),
        .is_jump        (is_jump),
        .is_jalr        (is_jalr),
        .is_trap_ret    (is_trap_ret),
        .is_load        (is_load),
        .mem_size       (mem_size),
        .gpr_we         (gpr_we),
        .csr_op         (csr_op),
        .csr_data       (csr_data),
        .src1           (src1),
        .src2           (src2),
        .stall          (stall),
        .alu_result     (alu_result),
        .alu_taken      (alu_taken),
        .out_ready      (out_ready),
        .pc_update      (pc_update),
        .in_ready       (in_ready),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .push           (push),
        .push_rd        (push_rd),
        .push_data      (push_data),
        .push_pending   (push_pending),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_rd         (out_rd),
        .out_gpr_we     (out_gpr_we),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_is_load    (out_is_load),
        .out_mem_size   (out_mem_size),
        .out_csr_we     (out_csr_we),
        .out_csr_wdata  (out_csr_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    exu_alu u_alu (
        .op     (alu_op),
        .br_op  (br_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (src1),
        .cmp_b  (src2),
        .result (alu_result),
        .taken  (alu_taken)
    );

    for (genvar i = 0; i < `EXU_FWD_DEPTH; i++) begin : g_slot
        reg_idx_t up_rd;
        word_t    up_data;
        logic     up_pending;

        if (i == 0) begin : g_head
            assign up_rd      = push_rd;    // new writer from the core.
            assign up_data    = push_data;
            assign up_pending = push_pending;
        end else begin : g_link
            assign up_rd      = slot_rd[i-1];
            assign up_data    = slot_data[i-1];
            assign up_pending = slot_pending[i-1];
        end

        forward_slot u_slot (
            .clk        (clk),
            .rst        (rst),
            .push       (push),
            .in_rd      (up_rd),
            .in_data    (up_data),
            .in_pending (up_pending),
            .fill_in    (fill_chain[i+1]),
            .fill_data  (load_data),
            .rd         (slot_rd[i]),
            .data       (slot_data[i]),
            .pending    (slot_pending[i]),
            .fill_out   (fill_chain[i])
        );
    end

    forward_select u_select (
        .rs1          (rs1),
        .rs2          (rs2),
        .reg1         (reg1),
        .reg2         (reg2),
        .slot_rd      (slot_rd),
        .slot_data    (slot_data),
        .slot_pending (slot_pending),
        .src1         (src1),
        .src2         (src2),
        .stall        (stall)
    );

endmodule

//--- logic/forward_select.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module forward_select (
    input  logic [`EXU_REG_W-1:0] rs1,
    input  logic [`EXU_REG_W-1:0] rs2,
    input  logic [`EXU_XLEN-1:0]  reg1,
    input  logic [`EXU_XLEN-1:0]  reg2,
    input  logic [`EXU_REG_W-1:0] slot_rd      [`EXU_FWD_DEPTH],
    input  logic [`EXU_XLEN-1:0]  slot_data    [`EXU_FWD_DEPTH],
    input  logic                  slot_pending [`EXU_FWD_DEPTH],
    output logic [`EXU_XLEN-1:0]  src1,
    output logic [`EXU_XLEN-1:0]  src2,
    output logic                  stall
);

    import exu_pkg::*;

    word_t sel1;
    word_t sel2;
    logic  wait1;
    logic  wait2;

    // walk from the oldest slot to slot 0 so the youngest match wins.
    always_comb begin
        sel1  = reg1;
        sel2  = reg2;
        wait1 = 1'b0;
        wait2 = 1'b0;
        for (int i = `EXU_FWD_DEPTH - 1; i >= 0; i--) begin
            if ((rs1 != '0) && (slot_rd[i] == rs1)) begin
                sel1  = slot_data[i];
                wait1 = slot_pending[i];
            end
            if ((rs2 != '0) && (slot_rd[i] == rs2)) begin
                sel2  = slot_data[i];
                wait2 = slot_pending[i];
            end
        end
    end

    assign src1  = sel1;
    assign src2  = sel2;
    assign stall = wait1 || wait2;    // an older non-pending writer is shadowed.

endmodule

//--- logic/forward_slot.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module forward_slot (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [`EXU_REG_W-1:0] in_rd,
    input  logic [`EXU_XLEN-1:0]  in_data,
    input  logic                  in_pending,
    input  logic                  fill_in,
    input  logic [`EXU_XLEN-1:0]  fill_data,
    output logic [`EXU_REG_W-1:0] rd,
    output logic [`EXU_XLEN-1:0]  data,
    output logic                  pending,
    output logic                  fill_out
);

    import exu_pkg::*;

    logic take_fill;

    // the token moves on toward slot 0 only past a slot with no pending load.
    assign fill_out  = fill_in && !pending;
    assign take_fill = fill_out && in_pending;    // younger neighbour is filled as it moves in.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd      <= '0;
            data    <= '0;
            pending <= 1'b0;
        end else if (push) begin
            rd      <= in_rd;
            data    <= take_fill ? fill_data : in_data;
            pending <= in_pending && !take_fill;
        end else if (fill_in && pending) begin
            data    <= fill_data;
            pending <= 1'b0;
        end
    end

endmodule

//--- sources.f
+incdir+logic
+incdir+bench
logic/exu_pkg.sv
logic/exu_alu.sv
logic/forward_slot.sv
logic/forward_select.sv
logic/exec_core.sv
logic/exu_top.sv
bench/exu_tb.sv
